//--- verilog/sched_params.svh
`ifndef SCHED_PARAMS_SVH
`define SCHED_PARAMS_SVH

// Scheduler sizing
`define SCHED_IF_COUNT        2
`define SCHED_CORE_COUNT      4
`define SCHED_SLOT_COUNT      8

// Core number is taken from the hash starting at this bit
`define SCHED_HASH_SEL_OFFSET 0
`define SCHED_HASH_WIDTH      32

// Tag field below the core number, slot sits in its low bits
`define SCHED_TAG_WIDTH       5

// Queue depths
`define SCHED_HASH_FIFO_DEPTH 4
`define SCHED_DONE_FIFO_DEPTH 8

// Control word layout
`define SCHED_MSG_TYPE_WIDTH  4
`define SCHED_CTRL_WIDTH      36

`endif

//--- verilog/sched_pkg.sv
package sched_pkg;

  `include "sched_params.svh"

  typedef logic [$clog2(`SCHED_CORE_COUNT)-1:0] core_id_t;
  typedef logic [$clog2(`SCHED_IF_COUNT)-1:0] if_id_t;

  // Holds 0 up to the full slot count
  typedef logic [$clog2(`SCHED_SLOT_COUNT+1)-1:0] slot_t;

  // Core number on top of the padded slot
  typedef logic [$bits(core_id_t)+`SCHED_TAG_WIDTH-1:0] desc_tag_t;

  typedef enum logic [`SCHED_MSG_TYPE_WIDTH-1:0] {
    SLOT_RETURN = 4'd0,
    PKT_DONE    = 4'd1,
    SLOT_INIT   = 4'd3
  } msg_type_e;

  // Outgoing send-out shares code 0 with the incoming slot return
  localparam msg_type_e SEND_OUT = SLOT_RETURN;

  typedef union packed {
    struct packed {
      msg_type_e   msg_type;
      logic [7:0]  rsvd_hi;
      logic [7:0]  slot;
      logic [15:0] rsvd_lo;
    } slot_msg;
    struct packed {
      msg_type_e                                        msg_type;
      logic [`SCHED_CTRL_WIDTH-`SCHED_MSG_TYPE_WIDTH-1:0] desc;
    } done_msg;
  } ctrl_msg_u;

endpackage

//--- verilog/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 4
) (
  input  logic             clk,
  input  logic             rst_r,
  input  logic             in_valid,
  output logic             in_ready,
  input  logic [WIDTH-1:0] in_data,
  output logic             out_valid,
  input  logic             out_ready,
  output logic [WIDTH-1:0] out_data
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [AW:0]      count;
  logic             push;
  logic             pop;

  assign in_ready  = (count != (AW+1)'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // A write refused while full must be offered again unchanged
  a_full_hold: assert property (@(posedge clk) disable iff (rst_r)
    (in_valid && !in_ready) |=> (in_valid && $stable(in_data)));

endmodule

//--- verilog/slot_keeper.sv
`timescale 1ns/1ps
`include "sched_params.svh"

module slot_keeper (
  input  logic             clk,
  input  logic             rst_r,
  input  logic             init_valid,
  input  sched_pkg::slot_t init_count,
  input  logic             ret_valid,
  input  sched_pkg::slot_t ret_slot,
  input  logic             pop,
  output sched_pkg::slot_t free_slot,
  output logic             free_valid,
  output sched_pkg::slot_t free_count,
  output logic             overflow
);

  import sched_pkg::*;

  localparam int SLOTS = `SCHED_SLOT_COUNT;
  localparam int AW    = $clog2(SLOTS);

  slot_t         mem [SLOTS];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  slot_t         count;
  slot_t         init_fill;
  logic          full;
  logic          ret_take;

  assign full      = (count == slot_t'(SLOTS));
  assign init_fill = (init_count > slot_t'(SLOTS)) ? slot_t'(SLOTS) : init_count;
  // A pop in the same cycle frees the entry the return lands in
  assign ret_take  = ret_valid && !init_valid && (!full || pop);

  assign free_slot  = mem[rd_ptr];
  assign free_valid = (count != '0);
  assign free_count = count;

  always_ff @(posedge clk) begin
    if (init_valid) begin
      for (int i = 0; i < SLOTS; i++) begin
        if (i < init_fill) begin
          mem[i] <= slot_t'(i + 1);
        end
      end
    end else if (ret_take) begin
      mem[wr_ptr] <= ret_slot;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      overflow <= ret_valid && !init_valid && full && !pop;
      if (init_valid) begin
        // Init restarts the queue at entry 0
        rd_ptr <= '0;
        wr_ptr <= AW'(init_fill % SLOTS);
        count  <= init_fill;
      end else begin
        if (ret_take) begin
          wr_ptr <= (wr_ptr == AW'(SLOTS - 1)) ? '0 : wr_ptr + 1'b1;
        end
        if (pop) begin
          rd_ptr <= (rd_ptr == AW'(SLOTS - 1)) ? '0 : rd_ptr + 1'b1;
        end
        if (ret_take && !pop) begin
          count <= count + 1'b1;
        end else if (pop && !ret_take) begin
          count <= count - 1'b1;
        end
      end
    end
  end

  a_no_empty_pop: assert property (@(posedge clk) disable iff (rst_r)
    pop |-> free_valid);

endmodule

//--- verilog/ctrl_msg_unit.sv
`timescale 1ns/1ps
`include "sched_params.svh"

module ctrl_msg_unit (
  input  logic                         clk,
  input  logic                         rst_r,
  input  logic                         ctrl_in_valid,
  output logic                         ctrl_in_ready,
  input  sched_pkg::ctrl_msg_u         ctrl_in_data,
  input  sched_pkg::core_id_t          ctrl_in_src,
  output logic [`SCHED_CORE_COUNT-1:0] slot_init_valid,
  output logic [`SCHED_CORE_COUNT-1:0] slot_ret_valid,
  output sched_pkg::slot_t             slot_value,
  output logic                         ctrl_out_valid,
  input  logic                         ctrl_out_ready,
  output sched_pkg::ctrl_msg_u         ctrl_out_data,
  output sched_pkg::core_id_t          ctrl_out_dest
);

  import sched_pkg::*;

  localparam int CORES  = `SCHED_CORE_COUNT;
  localparam int DESC_W = `SCHED_CTRL_WIDTH - `SCHED_MSG_TYPE_WIDTH;
  localparam int DONE_W = $bits(core_id_t) + DESC_W;

  logic              in_valid_r;
  ctrl_msg_u         in_word_r;
  core_id_t          in_src_r;
  msg_type_e         in_type;
  logic              is_done;
  logic              done_push;
  logic              done_ready;
  logic              drain;
  logic [CORES-1:0]  src_onehot;
  logic [DONE_W-1:0] done_in;
  logic [DONE_W-1:0] done_head;

  assign in_type    = in_word_r.slot_msg.msg_type;
  assign is_done    = (in_type == PKT_DONE);
  assign done_push  = in_valid_r && is_done;
  assign src_onehot = {{(CORES-1){1'b0}}, 1'b1} << in_src_r;
  assign done_in    = {in_src_r, in_word_r.done_msg.desc};

  // Slot and unknown words leave at once, packet-done waits for FIFO room
  assign drain         = in_valid_r && (!is_done || done_ready);
  assign ctrl_in_ready = !in_valid_r || drain;

  always_ff @(posedge clk) begin
    if (rst_r) begin
      in_valid_r <= 1'b0;
    end else if (ctrl_in_ready) begin
      in_valid_r <= ctrl_in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl_in_valid && ctrl_in_ready) begin
      in_word_r <= ctrl_in_data;
      in_src_r  <= ctrl_in_src;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      slot_init_valid <= '0;
      slot_ret_valid  <= '0;
    end else begin
      slot_init_valid <= (in_valid_r && in_type == SLOT_INIT) ? src_onehot : '0;
      slot_ret_valid  <= (in_valid_r && in_type == SLOT_RETURN) ? src_onehot : '0;
    end
  end

  // Count for init, slot number for return
  always_ff @(posedge clk) begin
    slot_value <= slot_t'(in_word_r.slot_msg.slot);
  end

  sync_fifo #(
    .WIDTH (DONE_W),
    .DEPTH (`SCHED_DONE_FIFO_DEPTH)
  ) u_done_fifo (
    .clk       (clk),
    .rst_r     (rst_r),
    .in_valid  (done_push),
    .in_ready  (done_ready),
    .in_data   (done_in),
    .out_valid (ctrl_out_valid),
    .out_ready (ctrl_out_ready),
    .out_data  (done_head)
  );

  // Done descriptor goes back to its source core as a send-out
  always_comb begin
    ctrl_out_dest                   = done_head[DONE_W-1 -: $bits(core_id_t)];
    ctrl_out_data.done_msg.msg_type = SEND_OUT;
    ctrl_out_data.done_msg.desc     = done_head[DESC_W-1:0];
  end

  a_strobe_onehot: assert property (@(posedge clk) disable iff (rst_r)
    $onehot0({slot_init_valid, slot_ret_valid}));

endmodule

//--- verilog/flow_desc_allocator.sv
`timescale 1ns/1ps
`include "sched_params.svh"

module flow_desc_allocator (
  input  logic                                              clk,
  input  logic                                              rst_r,
  input  logic [`SCHED_IF_COUNT-1:0]                        hash_valid,
  output logic [`SCHED_IF_COUNT-1:0]                        hash_ready,
  input  logic [`SCHED_IF_COUNT-1:0][`SCHED_HASH_WIDTH-1:0] hash,
  input  logic [`SCHED_CORE_COUNT-1:0]                      income_cores,
  input  sched_pkg::slot_t [`SCHED_CORE_COUNT-1:0]          free_slot,
  input  logic [`SCHED_CORE_COUNT-1:0]                      free_valid,
  output logic [`SCHED_CORE_COUNT-1:0]                      slot_pop,
  output logic [`SCHED_IF_COUNT-1:0]                        desc_valid,
  input  logic [`SCHED_IF_COUNT-1:0]                        desc_ready,
  output logic [`SCHED_IF_COUNT-1:0][`SCHED_HASH_WIDTH-1:0] desc_hash,
  output sched_pkg::desc_tag_t [`SCHED_IF_COUNT-1:0]        desc_tag
);

  import sched_pkg::*;

  localparam int IFS   = `SCHED_IF_COUNT;
  localparam int CORES = `SCHED_CORE_COUNT;
  localparam int HW    = `SCHED_HASH_WIDTH;
  localparam int DQ_W  = HW + $bits(desc_tag_t);

  logic [IFS-1:0][HW-1:0]   hq_data;
  logic [IFS-1:0]           hq_valid;
  logic [IFS-1:0]           hq_pop;
  logic [IFS-1:0]           dq_room;
  logic [IFS-1:0]           dq_push;
  logic [IFS-1:0][DQ_W-1:0] dq_out;
  logic [DQ_W-1:0]          dq_in;
  logic [IFS-1:0]           req;
  logic [IFS-1:0]           grant;
  if_id_t                   grant_id;
  if_id_t                   last_id;
  logic [IFS-1:0]           grant_r;
  if_id_t                   grant_id_r;
  core_id_t                 core_r;
  desc_tag_t                new_tag;
  logic                     go;

  for (genvar i = 0; i < IFS; i++) begin : g_if
    sync_fifo #(
      .WIDTH (HW),
      .DEPTH (`SCHED_HASH_FIFO_DEPTH)
    ) u_hash_fifo (
      .clk       (clk),
      .rst_r     (rst_r),
      .in_valid  (hash_valid[i]),
      .in_ready  (hash_ready[i]),
      .in_data   (hash[i]),
      .out_valid (hq_valid[i]),
      .out_ready (hq_pop[i]),
      .out_data  (hq_data[i])
    );

    sync_fifo #(
      .WIDTH (DQ_W),
      .DEPTH (`SCHED_HASH_FIFO_DEPTH)
    ) u_desc_fifo (
      .clk       (clk),
      .rst_r     (rst_r),
      .in_valid  (dq_push[i]),
      .in_ready  (dq_room[i]),
      .in_data   (dq_in),
      .out_valid (desc_valid[i]),
      .out_ready (desc_ready[i]),
      .out_data  (dq_out[i])
    );

    assign desc_hash[i] = dq_out[i][DQ_W-1 -: HW];
    assign desc_tag[i]  = dq_out[i][$bits(desc_tag_t)-1:0];
  end

  // The interface granted last cycle is still waiting on its slot check
  assign req = hq_valid & dq_room & ~grant_r;

  always_comb begin
    int   idx;
    logic found;
    grant    = '0;
    grant_id = last_id;
    found    = 1'b0;
    for (int k = 1; k <= IFS; k++) begin
      idx = (int'(last_id) + k) % IFS;
      if (!found && req[idx]) begin
        grant[idx] = 1'b1;
        grant_id   = if_id_t'(idx);
        found      = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      grant_r <= '0;
      last_id <= '0;
    end else begin
      grant_r <= grant;
      if (|grant) begin
        last_id <= grant_id;
      end
    end
  end

  always_ff @(posedge clk) begin
    grant_id_r <= grant_id;
    core_r     <= hq_data[grant_id][`SCHED_HASH_SEL_OFFSET +: $bits(core_id_t)];
  end

  // Nothing moves when the core is off or out of slots, so the request repeats
  assign go       = (|grant_r) && income_cores[core_r] && free_valid[core_r];
  assign slot_pop = go ? ({{(CORES-1){1'b0}}, 1'b1} << core_r) : '0;
  assign hq_pop   = go ? grant_r : '0;
  assign dq_push  = go ? grant_r : '0;

  assign new_tag = {core_r, {(`SCHED_TAG_WIDTH-$bits(slot_t)){1'b0}}, free_slot[core_r]};
  assign dq_in   = {hq_data[grant_id_r], new_tag};

  a_grant_onehot: assert property (@(posedge clk) disable iff (rst_r)
    $onehot0(grant_r));

endmodule

//--- verilog/hash_scheduler.sv
`timescale 1ns/1ps
`include "sched_params.svh"

module hash_scheduler (
  input  logic                                              clk,
  input  logic                                              rst_r,
  input  logic [`SCHED_IF_COUNT-1:0]                        hash_valid,
  output logic [`SCHED_IF_COUNT-1:0]                        hash_ready,
  input  logic [`SCHED_IF_COUNT-1:0][`SCHED_HASH_WIDTH-1:0] hash,
  output logic [`SCHED_IF_COUNT-1:0]                        desc_valid,
  input  logic [`SCHED_IF_COUNT-1:0]                        desc_ready,
  output logic [`SCHED_IF_COUNT-1:0][`SCHED_HASH_WIDTH-1:0] desc_hash,
  output sched_pkg::desc_tag_t [`SCHED_IF_COUNT-1:0]        desc_tag,
  input  logic                                              ctrl_in_valid,
  output logic                                              ctrl_in_ready,
  input  sched_pkg::ctrl_msg_u                              ctrl_in_data,
  input  sched_pkg::core_id_t                               ctrl_in_src,
  output logic                                              ctrl_out_valid,
  input  logic                                              ctrl_out_ready,
  output sched_pkg::ctrl_msg_u                              ctrl_out_data,
  output sched_pkg::core_id_t                               ctrl_out_dest,
  input  logic [`SCHED_CORE_COUNT-1:0]                      income_cores,
  input  sched_pkg::core_id_t                               stat_read_core,
  output sched_pkg::slot_t                                  slot_count
);

  import sched_pkg::*;

  localparam int CORES = `SCHED_CORE_COUNT;

  logic [CORES-1:0]  slot_init_valid;
  logic [CORES-1:0]  slot_ret_valid;
  slot_t             slot_value;
  slot_t [CORES-1:0] free_slot;
  logic [CORES-1:0]  free_valid;
  slot_t [CORES-1:0] free_count;
  logic [CORES-1:0]  slot_pop;
  logic [CORES-1:0]  overflow;
  core_id_t          stat_core_r;
  slot_t             count_sel_r;
  logic              slot_err_r;

  ctrl_msg_unit u_ctrl (
    .clk             (clk),
    .rst_r           (rst_r),
    .ctrl_in_valid   (ctrl_in_valid),
    .ctrl_in_ready   (ctrl_in_ready),
    .ctrl_in_data    (ctrl_in_data),
    .ctrl_in_src     (ctrl_in_src),
    .slot_init_valid (slot_init_valid),
    .slot_ret_valid  (slot_ret_valid),
    .slot_value      (slot_value),
    .ctrl_out_valid  (ctrl_out_valid),
    .ctrl_out_ready  (ctrl_out_ready),
    .ctrl_out_data   (ctrl_out_data),
    .ctrl_out_dest   (ctrl_out_dest)
  );

  flow_desc_allocator u_alloc (
    .clk          (clk),
    .rst_r        (rst_r),
    .hash_valid   (hash_valid),
    .hash_ready   (hash_ready),
    .hash         (hash),
    .income_cores (income_cores),
    .free_slot    (free_slot),
    .free_valid   (free_valid),
    .slot_pop     (slot_pop),
    .desc_valid   (desc_valid),
    .desc_ready   (desc_ready),
    .desc_hash    (desc_hash),
    .desc_tag     (desc_tag)
  );

  for (genvar c = 0; c < CORES; c++) begin : g_core
    slot_keeper u_keeper (
      .clk        (clk),
      .rst_r      (rst_r),
      .init_valid (slot_init_valid[c]),
      .init_count (slot_value),
      .ret_valid  (slot_ret_valid[c]),
      .ret_slot   (slot_value),
      .pop        (slot_pop[c]),
      .free_slot  (free_slot[c]),
      .free_valid (free_valid[c]),
      .free_count (free_count[c]),
      .overflow   (overflow[c])
    );
  end

  // Two register stages between the keepers and the readback port
  always_ff @(posedge clk) begin
    if (rst_r) begin
      stat_core_r <= '0;
      count_sel_r <= '0;
      slot_count  <= '0;
      slot_err_r  <= 1'b0;
    end else begin
      stat_core_r <= stat_read_core;
      count_sel_r <= free_count[stat_core_r];
      slot_count  <= count_sel_r;
      slot_err_r  <= slot_err_r | (|overflow);
    end
  end

  // Cores never return more slots than they were given
  a_no_slot_err: assert property (@(posedge clk) disable iff (rst_r)
    !slot_err_r);

endmodule

//--- bench/tb_hash_scheduler.sv
`timescale 1ns/1ps
`include "sched_params.svh"

module tb_hash_scheduler;

  import sched_pkg::*;

  localparam int IFS   = `SCHED_IF_COUNT;
  localparam int CORES = `SCHED_CORE_COUNT;
  localparam int SLOTS = `SCHED_SLOT_COUNT;

  // Step kinds
  localparam logic [3:0] K_COUNT = 4'd0;
  localparam logic [3:0] K_INIT  = 4'd1;
  localparam logic [3:0] K_RET   = 4'd2;
  localparam logic [3:0] K_HASH  = 4'd3;
  localparam logic [3:0] K_BURST = 4'd4;
  localparam logic [3:0] K_HELD  = 4'd5;
  localparam logic [3:0] K_ENA   = 4'd6;
  localparam logic [3:0] K_DONE  = 4'd7;
  localparam logic [3:0] K_SYNC  = 4'd8;

  // Control word type codes
  localparam logic [3:0] T_RETURN = 4'h0;
  localparam logic [3:0] T_DONE   = 4'h1;
  localparam logic [3:0] T_INIT   = 4'h3;
  localparam logic [3:0] T_SEND   = 4'h0;

  typedef struct packed {
    logic [3:0]  kind;
    logic [1:0]  core;
    logic [3:0]  val;
    logic [31:0] hash;
    logic        intf;
    logic [3:0]  exp;
  } step_t;

  localparam int NSTEPS      = 48;
  localparam int CYCLE_LIMIT = 50 * NSTEPS + 200;

  // kind, core, slot or count or enable mask, hash or descriptor, interface, expected count
  localparam step_t STEPS [NSTEPS] = '{
    '{K_COUNT, 2'd0, 4'd0, 32'h0000_0000, 1'b0, 4'd0},
    '{K_COUNT, 2'd1, 4'd0, 32'h0000_0000, 1'b0, 4'd0},
    '{K_COUNT, 2'd2, 4'd0, 32'h0000_0000, 1'b0, 4'd0},
    '{K_COUNT, 2'd3, 4'd0, 32'h0000_0000, 1'b0, 4'd0},
    '{K_INIT,  2'd0, 4'd8, 32'h0000_0000, 1'b0, 4'd0},
    '{K_INIT,  2'd1, 4'd3, 32'h0000_0000, 1'b0, 4'd0},
    '{K_INIT,  2'd2, 4'd5, 32'h0000_0000, 1'b0, 4'd0},
    '{K_INIT,  2'd3, 4'd2, 32'h0000_0000, 1'b0, 4'd0},
    '{K_COUNT, 2'd0, 4'd0, 32'h0000_0000, 1'b0, 4'd8},
    '{K_COUNT, 2'd1, 4'd0, 32'h0000_0000, 1'b0, 4'd3},
    '{K_COUNT, 2'd2, 4'd0, 32'h0000_0000, 1'b0, 4'd5},
    '{K_COUNT, 2'd3, 4'd0, 32'h0000_0000, 1'b0, 4'd2},
    '{K_HASH,  2'd0, 4'd0, 32'hA5A5_0001, 1'b0, 4'd0},
    '{K_HASH,  2'd0, 4'd0, 32'h0F0F_0002, 1'b1, 4'd0},
    '{K_HASH,  2'd0, 4'd0, 32'h1111_0004, 1'b0, 4'd0},
    '{K_HASH,  2'd0, 4'd0, 32'h2222_0007, 1'b1, 4'd0},
    '{K_HASH,  2'd0, 4'd0, 32'h3333_000B, 1'b0, 4'd0},
    '{K_HASH,  2'd0, 4'd0, 32'h4444_0005, 1'b1, 4'd0},
    '{K_HASH,  2'd0, 4'd0, 32'h5555_0009, 1'b0, 4'd0},
    '{K_HELD,  2'd0, 4'd0, 32'h7777_000D, 1'b0, 4'd0},
    '{K_RET,   2'd1, 4'd2, 32'h0000_0000, 1'b0, 4'd0},
    '{K_SYNC,  2'd0, 4'd0, 32'h0000_0000, 1'b0, 4'd0},
    '{K_RET,   2'd0, 4'd1, 32'h0000_0000, 1'b0, 4'd0},
    '{K_COUNT, 2'd0, 4'd0, 32'h0000_0000, 1'b0, 4'd8},
    '{K_ENA,   2'd0, 4'b1011, 32'h0000_0000, 1'b0, 4'd0},
    '{K_HELD,  2'd0, 4'd0, 32'h8888_0006, 1'b1, 4'd0},
    '{K_ENA,   2'd0, 4'b1111, 32'h0000_0000, 1'b0, 4'd0},
    '{K_SYNC,  2'd0, 4'd0, 32'h0000_0000, 1'b0, 4'd0},
    '{K_BURST, 2'd0, 4'd0, 32'h9000_0000, 1'b0, 4'd0},
    '{K_BURST, 2'd0, 4'd0, 32'hA000_0002, 1'b1, 4'd0},
    '{K_BURST, 2'd0, 4'd0, 32'h9000_0004, 1'b0, 4'd0},
    '{K_BURST, 2'd0, 4'd0, 32'h9000_0008, 1'b0, 4'd0},
    '{K_BURST, 2'd0, 4'd0, 32'hA000_0006, 1'b1, 4'd0},
    '{K_BURST, 2'd0, 4'd0, 32'h9000_000C, 1'b0, 4'd0},
    '{K_BURST, 2'd0, 4'd0, 32'h9000_0010, 1'b0, 4'd0},
    '{K_BURST, 2'd0, 4'd0, 32'hA000_000A, 1'b1, 4'd0},
    '{K_BURST, 2'd0, 4'd0, 32'h9000_0014, 1'b0, 4'd0},
    '{K_BURST, 2'd0, 4'd0, 32'h9000_0018, 1'b0, 4'd0},
    '{K_SYNC,  2'd0, 4'd0, 32'h0000_0000, 1'b0, 4'd0},
    '{K_HASH,  2'd0, 4'd0, 32'h9100_0000, 1'b1, 4'd0},
    '{K_COUNT, 2'd0, 4'd0, 32'h0000_0000, 1'b0, 4'd0},
    '{K_COUNT, 2'd2, 4'd0, 32'h0000_0000, 1'b0, 4'd0},
    '{K_DONE,  2'd1, 4'd0, 32'hDEAD_BEEF, 1'b0, 4'd0},
    '{K_DONE,  2'd3, 4'd0, 32'h0123_4567, 1'b0, 4'd0},
    '{K_DONE,  2'd0, 4'd0, 32'h89AB_CDEF, 1'b0, 4'd0},
    '{K_DONE,  2'd2, 4'd0, 32'h5A5A_C3C3, 1'b0, 4'd0},
    '{K_DONE,  2'd1, 4'd0, 32'h0BAD_F00D, 1'b0, 4'd0},
    '{K_SYNC,  2'd0, 4'd0, 32'h0000_0000, 1'b0, 4'd0}
  };

  logic                 clk;
  logic                 rst_r;
  logic [IFS-1:0]       hash_valid;
  logic [IFS-1:0]       hash_ready;
  logic [IFS-1:0][31:0] hash;
  logic [IFS-1:0]       desc_valid;
  logic [IFS-1:0]       desc_ready;
  logic [IFS-1:0][31:0] desc_hash;
  desc_tag_t [IFS-1:0]  desc_tag;
  logic                 ctrl_in_valid;
  logic                 ctrl_in_ready;
  ctrl_msg_u            ctrl_in_data;
  core_id_t             ctrl_in_src;
  logic                 ctrl_out_valid;
  logic                 ctrl_out_ready;
  ctrl_msg_u            ctrl_out_data;
  core_id_t             ctrl_out_dest;
  logic [CORES-1:0]     income_cores;
  core_id_t             stat_read_core;
  slot_t                slot_count;

  // Reference slot queues and expected outputs
  int          model_q [CORES][$];
  logic [38:0] exp_q [IFS][$];
  logic [33:0] done_q [$];
  logic        pend_valid = 1'b0;
  logic        pend_intf;
  logic [31:0] pend_hash;
  logic        out_hold = 1'b0;
  ctrl_msg_u   out_prev;
  core_id_t    dest_prev;
  logic        seeded = 1'b0;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;

  hash_scheduler u_dut (
    .clk            (clk),
    .rst_r          (rst_r),
    .hash_valid     (hash_valid),
    .hash_ready     (hash_ready),
    .hash           (hash),
    .desc_valid     (desc_valid),
    .desc_ready     (desc_ready),
    .desc_hash      (desc_hash),
    .desc_tag       (desc_tag),
    .ctrl_in_valid  (ctrl_in_valid),
    .ctrl_in_ready  (ctrl_in_ready),
    .ctrl_in_data   (ctrl_in_data),
    .ctrl_in_src    (ctrl_in_src),
    .ctrl_out_valid (ctrl_out_valid),
    .ctrl_out_ready (ctrl_out_ready),
    .ctrl_out_data  (ctrl_out_data),
    .ctrl_out_dest  (ctrl_out_dest),
    .income_cores   (income_cores),
    .stat_read_core (stat_read_core),
    .slot_count     (slot_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] want);
    $display("ERROR: %s got %0h expected %0h", name, got, want);
    errors++;
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  task automatic take_desc(input int i);
    logic [38:0] e;
    checks++;
    assert (exp_q[i].size() != 0) else
      report_failure($sformatf("Unexpected descriptor on interface %0d", i));
    if (exp_q[i].size() != 0) begin
      e = exp_q[i].pop_front();
      assert (desc_hash[i] == e[38:7]) else
        report_mismatch($sformatf("desc_hash[%0d]", i), desc_hash[i], e[38:7]);
      assert (desc_tag[i] == e[6:0]) else
        report_mismatch($sformatf("desc_tag[%0d]", i), desc_tag[i], e[6:0]);
    end
  endtask

  task automatic take_done();
    logic [33:0] e;
    checks++;
    assert (done_q.size() != 0) else report_failure("Send-out message with nothing pending");
    if (done_q.size() != 0) begin
      e = done_q.pop_front();
      assert (ctrl_out_data.done_msg.msg_type == T_SEND) else
        report_mismatch("ctrl_out_data type", ctrl_out_data.done_msg.msg_type, T_SEND);
      assert (ctrl_out_data.done_msg.desc == e[31:0]) else
        report_mismatch("ctrl_out_data desc", ctrl_out_data.done_msg.desc, e[31:0]);
      assert (ctrl_out_dest == e[33:32]) else
        report_mismatch("ctrl_out_dest", ctrl_out_dest, e[33:32]);
    end
  endtask

  // Outputs settle after the edge, inputs change on the falling edge
  always @(posedge clk) begin
    if (!rst_r) begin
      for (int i = 0; i < IFS; i++) begin
        if (desc_valid[i] && desc_ready[i]) begin
          take_desc(i);
        end
      end
      if (ctrl_out_valid && ctrl_out_ready) begin
        take_done();
      end
      if (out_hold) begin
        assert (ctrl_out_valid && ctrl_out_data == out_prev && ctrl_out_dest == dest_prev)
          else report_failure("Send-out message changed while ctrl_out_ready was low");
      end
      out_hold  = ctrl_out_valid && !ctrl_out_ready;
      out_prev  = ctrl_out_data;
      dest_prev = ctrl_out_dest;
    end
  end

  always @(negedge clk) begin
    if (!seeded) begin
      void'($urandom(32'h0479_ee2d));
      seeded = 1'b1;
    end
    desc_ready[0]  = ($urandom % 4) != 0;
    desc_ready[1]  = ($urandom % 4) != 0;
    ctrl_out_ready = ($urandom % 3) != 0;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles with work still pending", cycles);
      $display("Checks %0d, errors %0d", checks, errors + 1);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic send_ctrl(input logic [3:0] typ, input logic [1:0] src,
                           input logic [31:0] body);
    @(negedge clk);
    ctrl_in_valid = 1'b1;
    ctrl_in_data  = {typ, body};
    ctrl_in_src   = src;
    do @(posedge clk); while (!ctrl_in_ready);
    @(negedge clk);
    ctrl_in_valid = 1'b0;
  endtask

  task automatic send_hash(input logic intf, input logic [31:0] value);
    @(negedge clk);
    hash_valid[intf] = 1'b1;
    hash[intf]       = value;
    do @(posedge clk); while (!hash_ready[intf]);
    @(negedge clk);
    hash_valid[intf] = 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_q[0].size() != 0 || exp_q[1].size() != 0 || done_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  // A held hash leaves once its core is enabled and has a slot
  task automatic release_held();
    logic [1:0] core;
    int         slot;
    core = pend_hash[`SCHED_HASH_SEL_OFFSET +: 2];
    if (pend_valid && income_cores[core] && model_q[core].size() != 0) begin
      slot = model_q[core].pop_front();
      exp_q[pend_intf].push_back({pend_hash, core, 5'(slot)});
      pend_valid = 1'b0;
    end
  endtask

  task automatic check_count(input logic [1:0] core, input logic [3:0] want);
    wait_idle();
    @(negedge clk);
    stat_read_core = core;
    repeat (6) @(posedge clk);
    checks++;
    assert (slot_count == want) else
      report_mismatch($sformatf("slot_count core %0d", core), slot_count, want);
  endtask

  task automatic run_step(input step_t s);
    logic [1:0] core;
    int         slot;
    core = s.hash[`SCHED_HASH_SEL_OFFSET +: 2];
    case (s.kind)
      K_COUNT: check_count(s.core, s.exp);
      K_INIT: begin
        send_ctrl(T_INIT, s.core, {8'h00, 4'h0, s.val, 16'h0000});
        model_q[s.core].delete();
        for (int k = 1; k <= int'(s.val) && k <= SLOTS; k++) begin
          model_q[s.core].push_back(k);
        end
      end
      K_RET: begin
        send_ctrl(T_RETURN, s.core, {8'h00, 4'h0, s.val, 16'h0000});
        if (model_q[s.core].size() < SLOTS) begin
          model_q[s.core].push_back(int'(s.val));
        end
        release_held();
      end
      K_HASH, K_BURST: begin
        assert (income_cores[core] && model_q[core].size() != 0) else
          report_failure("Hash row aimed at a core without a free slot");
        slot = model_q[core].pop_front();
        exp_q[s.intf].push_back({s.hash, core, 5'(slot)});
        send_hash(s.intf, s.hash);
        if (s.kind == K_HASH) begin
          wait_idle();
        end
      end
      K_HELD: begin
        pend_valid = 1'b1;
        pend_intf  = s.intf;
        pend_hash  = s.hash;
        send_hash(s.intf, s.hash);
        repeat (20) @(negedge clk);
        assert (!desc_valid[s.intf]) else
          report_failure("Descriptor produced for a hash whose core cannot take it");
      end
      K_ENA: begin
        @(negedge clk);
        income_cores = s.val;
        release_held();
      end
      K_DONE: begin
        done_q.push_back({s.core, s.hash});
        send_ctrl(T_DONE, s.core, s.hash);
      end
      default: wait_idle();
    endcase
  endtask

  initial begin
    rst_r          = 1'b1;
    hash_valid     = '0;
    hash           = '0;
    desc_ready     = '0;
    ctrl_in_valid  = 1'b0;
    ctrl_in_data   = '0;
    ctrl_in_src    = '0;
    ctrl_out_ready = 1'b0;
    income_cores   = 4'b1111;
    stat_read_core = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_r = 1'b0;

    checks++;
    assert (desc_valid == '0 && !ctrl_out_valid && hash_ready == '1) else
      report_failure("Outputs not idle after reset");

    for (int n = 0; n < NSTEPS; n++) begin
      run_step(STEPS[n]);
    end
    wait_idle();
    repeat (4) @(negedge clk);
    assert (!pend_valid) else report_failure("Held hash never became a descriptor");

    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+verilog
verilog/sched_pkg.sv
verilog/sync_fifo.sv
verilog/slot_keeper.sv
verilog/ctrl_msg_unit.sv
verilog/flow_desc_allocator.sv
verilog/hash_scheduler.sv
bench/tb_hash_scheduler.sv

//--- run.sh
#!/bin/sh
# Build and run the scheduler testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module tb_hash_scheduler > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_hash_scheduler > sim.log 2>&1 || true
cat sim.log
grep -qx "STATUS: PASS" sim.log && echo "run passed" || { echo "run failed"; exit 1; }
